/* Makefile */
VERILATOR := verilator
VFLAGS    := --binary --timing -Icommon
TOP       := mem_subsys_tb
FILELIST  := compile.f

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, and look for the pass message"
	@echo "  clean  remove the obj_dir build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Result: PASSED"

clean:
	rm -rf obj_dir

/* common/mem_params.svh */
`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

// Byte address width on the DRAM side
`define MEM_ADDR_WIDTH 28

// Data word width, byte strobes follow from it
`define MEM_DATA_WIDTH 32

// Command FIFO entries between bridge and memory
`define MEM_FIFO_DEPTH 4

// Words implemented by the memory model
// Any higher word address decodes as an error
`define MEM_WORDS 1024

// One refresh stall cycle per interval
`define MEM_REFRESH_INTERVAL 16

`endif

/* common/mem_pkg.sv */
`include "mem_params.svh"

package mem_pkg;

   // Byte address into the DRAM space
   typedef logic [`MEM_ADDR_WIDTH-1:0] mem_addr_t;

   // One data word and its byte enables
   typedef logic [`MEM_DATA_WIDTH-1:0]   mem_data_t;
   typedef logic [`MEM_DATA_WIDTH/8-1:0] mem_strb_t;

   // Response code, AXI encoding
   typedef logic [1:0] mem_resp_t;

   localparam mem_resp_t RESP_OKAY   = 2'b00;
   localparam mem_resp_t RESP_DECERR = 2'b11;

   // Bridge FSM
   typedef enum logic [1:0] {
      ST_IDLE,
      ST_READ_WAIT,
      ST_READ_DONE
   } bridge_state_t;

endpackage

/* compile.f */
+incdir+common
common/mem_pkg.sv
design/wb2axi/wb2axi.sv
design/mem_cmd_fifo.sv
design/ddr_mem/ddr_mem.sv
design/mem_subsys_top.sv
verification/mem_subsys_tb.sv

/* design/ddr_mem/ddr_mem.sv */
`include "mem_params.svh"

module ddr_mem (
   input  logic               clk,
   input  logic               rst_n_i,

   // Command stream
   input  logic               cmd_valid_i,
   output logic               cmd_ready_o,
   input  logic               cmd_we_i,
   input  mem_pkg::mem_addr_t cmd_addr_i,
   input  mem_pkg::mem_data_t cmd_data_i,
   input  mem_pkg::mem_strb_t cmd_strb_i,

   // Response, one pulse per accepted command
   output logic               rsp_valid_o,
   output logic               rsp_we_o,
   output mem_pkg::mem_resp_t rsp_resp_o,
   output mem_pkg::mem_data_t rsp_data_o
);

   import mem_pkg::*;

   localparam int WORD_BYTES  = `MEM_DATA_WIDTH / 8;
   localparam int BYTE_OFFS   = $clog2(WORD_BYTES);
   localparam int IDX_WIDTH   = $clog2(`MEM_WORDS);
   localparam int CNT_WIDTH   = $clog2(`MEM_REFRESH_INTERVAL);

   // Word address, byte offset dropped
   typedef logic [`MEM_ADDR_WIDTH-BYTE_OFFS-1:0] word_addr_t;

   mem_data_t            mem_q [`MEM_WORDS];
   logic [CNT_WIDTH-1:0] refresh_cnt_q;
   logic                 refresh;
   logic                 accept;
   word_addr_t           word_addr;
   logic                 in_range;
   logic [IDX_WIDTH-1:0] idx;

   // Last slot of every interval is a refresh cycle
   assign refresh     = (refresh_cnt_q == CNT_WIDTH'(`MEM_REFRESH_INTERVAL-1));
   assign cmd_ready_o = ~refresh;
   assign accept      = cmd_valid_i & cmd_ready_o;

   // Range decode
   assign word_addr = cmd_addr_i[`MEM_ADDR_WIDTH-1:BYTE_OFFS];
   assign in_range  = (word_addr < `MEM_WORDS);
   assign idx       = word_addr[IDX_WIDTH-1:0];

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         refresh_cnt_q <= '0;
      end else if (refresh) begin
         refresh_cnt_q <= '0;
      end else begin
         refresh_cnt_q <= refresh_cnt_q + 1'b1;
      end
   end

   // Array comes up zeroed after reset
   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         for (int i = 0; i < `MEM_WORDS; i++) begin
            mem_q[i] <= '0;
         end
      end else if (accept && cmd_we_i && in_range) begin
         for (int b = 0; b < WORD_BYTES; b++) begin
            if (cmd_strb_i[b]) begin
               mem_q[idx][8*b +: 8] <= cmd_data_i[8*b +: 8];
            end
         end
      end
   end

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         rsp_valid_o <= 1'b0;
      end else begin
         rsp_valid_o <= accept;
      end
   end

   always_ff @(posedge clk) begin
      if (accept) begin
         rsp_we_o   <= cmd_we_i;
         rsp_resp_o <= in_range ? RESP_OKAY : RESP_DECERR;
         // Writes and bad reads return zero data
         if (!cmd_we_i && in_range) begin
            rsp_data_o <= mem_q[idx];
         end else begin
            rsp_data_o <= '0;
         end
      end
   end

endmodule

/* design/mem_cmd_fifo.sv */
`include "mem_params.svh"

module mem_cmd_fifo (
   input  logic               clk,
   input  logic               rst_n_i,

   // Write side, from the bridge
   input  logic               in_valid_i,
   output logic               in_ready_o,
   input  logic               in_we_i,
   input  mem_pkg::mem_addr_t in_addr_i,
   input  mem_pkg::mem_data_t in_data_i,
   input  mem_pkg::mem_strb_t in_strb_i,

   // Read side, toward memory
   output logic               out_valid_o,
   input  logic               out_ready_i,
   output logic               out_we_o,
   output mem_pkg::mem_addr_t out_addr_o,
   output mem_pkg::mem_data_t out_data_o,
   output mem_pkg::mem_strb_t out_strb_o
);

   import mem_pkg::*;

   localparam int DEPTH     = `MEM_FIFO_DEPTH;
   localparam int PTR_WIDTH = (DEPTH > 1) ? $clog2(DEPTH) : 1;

   // Entry storage
   logic      we_q   [DEPTH];
   mem_addr_t addr_q [DEPTH];
   mem_data_t data_q [DEPTH];
   mem_strb_t strb_q [DEPTH];

   logic [PTR_WIDTH-1:0] wr_ptr_q;
   logic [PTR_WIDTH-1:0] rd_ptr_q;
   logic [PTR_WIDTH:0]   count_q;
   logic                 push;
   logic                 pop;

   assign in_ready_o  = (count_q != (PTR_WIDTH+1)'(DEPTH));
   assign out_valid_o = (count_q != '0);

   assign push = in_valid_i & in_ready_o;
   assign pop  = out_valid_o & out_ready_i;

   // Head entry straight from the storage flops
   assign out_we_o   = we_q[rd_ptr_q];
   assign out_addr_o = addr_q[rd_ptr_q];
   assign out_data_o = data_q[rd_ptr_q];
   assign out_strb_o = strb_q[rd_ptr_q];

   always_ff @(posedge clk) begin
      if (push) begin
         we_q[wr_ptr_q]   <= in_we_i;
         addr_q[wr_ptr_q] <= in_addr_i;
         data_q[wr_ptr_q] <= in_data_i;
         strb_q[wr_ptr_q] <= in_strb_i;
      end
   end

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (push) begin
            wr_ptr_q <= (wr_ptr_q == PTR_WIDTH'(DEPTH-1)) ? '0 : wr_ptr_q + 1'b1;
         end
         if (pop) begin
            rd_ptr_q <= (rd_ptr_q == PTR_WIDTH'(DEPTH-1)) ? '0 : rd_ptr_q + 1'b1;
         end
         // Simultaneous push and pop leaves the count alone
         if (push && !pop) begin
            count_q <= count_q + 1'b1;
         end else if (pop && !push) begin
            count_q <= count_q - 1'b1;
         end
      end
   end

endmodule

/* design/mem_subsys_top.sv */
module mem_subsys_top (
   input  logic               clk,
   input  logic               rst_n_i,

   // Wishbone slave port of the DRAM path
   input  logic               wb_cyc_i,
   input  logic               wb_stb_i,
   input  logic               wb_we_i,
   input  mem_pkg::mem_addr_t wb_adr_i,
   input  mem_pkg::mem_data_t wb_dat_i,
   input  mem_pkg::mem_strb_t wb_sel_i,
   output logic               wb_ack_o,
   output logic               wb_err_o,
   output mem_pkg::mem_data_t wb_dat_o,

   output logic               wr_err_o
);

   import mem_pkg::*;

   // Bridge to FIFO
   logic      cmd_valid;
   logic      cmd_ready;
   logic      cmd_we;
   mem_addr_t cmd_addr;
   mem_data_t cmd_data;
   mem_strb_t cmd_strb;

   // FIFO to memory
   logic      mem_cmd_valid;
   logic      mem_cmd_ready;
   logic      mem_cmd_we;
   mem_addr_t mem_cmd_addr;
   mem_data_t mem_cmd_data;
   mem_strb_t mem_cmd_strb;

   // Memory back to bridge
   logic      rsp_valid;
   logic      rsp_we;
   mem_resp_t rsp_resp;
   mem_data_t rsp_data;

   wb2axi u_wb2axi (
      .clk         (clk),
      .rst_n_i     (rst_n_i),
      .wb_cyc_i    (wb_cyc_i),
      .wb_stb_i    (wb_stb_i),
      .wb_we_i     (wb_we_i),
      .wb_adr_i    (wb_adr_i),
      .wb_dat_i    (wb_dat_i),
      .wb_sel_i    (wb_sel_i),
      .wb_ack_o    (wb_ack_o),
      .wb_err_o    (wb_err_o),
      .wb_dat_o    (wb_dat_o),
      .cmd_valid_o (cmd_valid),
      .cmd_ready_i (cmd_ready),
      .cmd_we_o    (cmd_we),
      .cmd_addr_o  (cmd_addr),
      .cmd_data_o  (cmd_data),
      .cmd_strb_o  (cmd_strb),
      .rsp_valid_i (rsp_valid),
      .rsp_we_i    (rsp_we),
      .rsp_resp_i  (rsp_resp),
      .rsp_data_i  (rsp_data),
      .wr_err_o    (wr_err_o)
   );

   mem_cmd_fifo u_cmd_fifo (
      .clk         (clk),
      .rst_n_i     (rst_n_i),
      .in_valid_i  (cmd_valid),
      .in_ready_o  (cmd_ready),
      .in_we_i     (cmd_we),
      .in_addr_i   (cmd_addr),
      .in_data_i   (cmd_data),
      .in_strb_i   (cmd_strb),
      .out_valid_o (mem_cmd_valid),
      .out_ready_i (mem_cmd_ready),
      .out_we_o    (mem_cmd_we),
      .out_addr_o  (mem_cmd_addr),
      .out_data_o  (mem_cmd_data),
      .out_strb_o  (mem_cmd_strb)
   );

   ddr_mem u_ddr_mem (
      .clk         (clk),
      .rst_n_i     (rst_n_i),
      .cmd_valid_i (mem_cmd_valid),
      .cmd_ready_o (mem_cmd_ready),
      .cmd_we_i    (mem_cmd_we),
      .cmd_addr_i  (mem_cmd_addr),
      .cmd_data_i  (mem_cmd_data),
      .cmd_strb_i  (mem_cmd_strb),
      .rsp_valid_o (rsp_valid),
      .rsp_we_o    (rsp_we),
      .rsp_resp_o  (rsp_resp),
      .rsp_data_o  (rsp_data)
   );

endmodule

/* design/wb2axi/wb2axi.sv */
module wb2axi (
   input  logic               clk,
   input  logic               rst_n_i,

   // Wishbone classic slave
   input  logic               wb_cyc_i,
   input  logic               wb_stb_i,
   input  logic               wb_we_i,
   input  mem_pkg::mem_addr_t wb_adr_i,
   input  mem_pkg::mem_data_t wb_dat_i,
   input  mem_pkg::mem_strb_t wb_sel_i,
   output logic               wb_ack_o,
   output logic               wb_err_o,
   output mem_pkg::mem_data_t wb_dat_o,

   // Command stream toward the FIFO
   output logic               cmd_valid_o,
   input  logic               cmd_ready_i,
   output logic               cmd_we_o,
   output mem_pkg::mem_addr_t cmd_addr_o,
   output mem_pkg::mem_data_t cmd_data_o,
   output mem_pkg::mem_strb_t cmd_strb_o,

   // Response stream from memory, always accepted
   input  logic               rsp_valid_i,
   input  logic               rsp_we_i,
   input  mem_pkg::mem_resp_t rsp_resp_i,
   input  mem_pkg::mem_data_t rsp_data_i,

   // Sticky flag for a failed posted write
   output logic               wr_err_o
);

   import mem_pkg::*;

   bridge_state_t state_q;
   logic          ack_q;
   logic          err_q;
   mem_data_t     rdata_q;
   logic          wr_err_q;
   logic          wb_req;
   logic          cmd_fire;
   logic          rd_rsp;
   logic          rd_decerr;

   // A held stb during its own ack cycle is not a new request
   assign wb_req = wb_cyc_i & wb_stb_i & ~ack_q;

   assign cmd_valid_o = (state_q == ST_IDLE) & wb_req;
   assign cmd_we_o    = wb_we_i;
   assign cmd_addr_o  = wb_adr_i;
   assign cmd_data_o  = wb_dat_i;
   assign cmd_strb_o  = wb_sel_i;

   assign cmd_fire = cmd_valid_o & cmd_ready_i;

   // Only one read is outstanding, so the first read response is ours
   assign rd_rsp    = rsp_valid_i & ~rsp_we_i;
   assign rd_decerr = (rsp_resp_i == RESP_DECERR);

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         state_q <= ST_IDLE;
         ack_q   <= 1'b0;
         err_q   <= 1'b0;
      end else begin
         ack_q <= 1'b0;
         err_q <= 1'b0;
         unique case (state_q)
            ST_IDLE: begin
               if (cmd_fire) begin
                  // Writes are posted and acked on transfer
                  if (wb_we_i) begin
                     ack_q <= 1'b1;
                  end else begin
                     state_q <= ST_READ_WAIT;
                  end
               end
            end
            ST_READ_WAIT: begin
               if (rd_rsp) begin
                  ack_q   <= ~rd_decerr;
                  err_q   <= rd_decerr;
                  state_q <= ST_READ_DONE;
               end
            end
            ST_READ_DONE: begin
               // Ack cycle, master still holds stb here
               state_q <= ST_IDLE;
            end
            default: begin
               state_q <= ST_IDLE;
            end
         endcase
      end
   end

   // Read data capture
   always_ff @(posedge clk) begin
      if ((state_q == ST_READ_WAIT) && rd_rsp) begin
         rdata_q <= rsp_data_i;
      end
   end

   // Write decode errors can only be reported out of band
   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         wr_err_q <= 1'b0;
      end else if (rsp_valid_i && rsp_we_i && rd_decerr) begin
         wr_err_q <= 1'b1;
      end
   end

   assign wb_ack_o = ack_q;
   assign wb_err_o = err_q;
   assign wb_dat_o = rdata_q;
   assign wr_err_o = wr_err_q;

endmodule

/* verification/mem_subsys_tb.sv */
`include "mem_params.svh"

module mem_subsys_tb;

   import mem_pkg::*;

   localparam int CLK_PERIOD  = 100;
   localparam int DRIVE_DELAY = 10;
   localparam int STRB_WIDTH  = `MEM_DATA_WIDTH / 8;
   localparam int BYTE_OFFS   = $clog2(STRB_WIDTH);
   localparam int IDX_WIDTH   = $clog2(`MEM_WORDS);

   logic      clk;
   logic      rst_n;
   logic      wb_cyc;
   logic      wb_stb;
   logic      wb_we;
   mem_addr_t wb_adr;
   mem_data_t wb_dat_wr;
   mem_strb_t wb_sel;
   logic      wb_ack;
   logic      wb_err;
   mem_data_t wb_dat_rd;
   logic      wr_err;

   // Stimulus table, one Wishbone cycle per row
   string     row_name     [$];
   logic      row_we       [$];
   mem_addr_t row_addr     [$];
   mem_data_t row_data     [$];
   mem_strb_t row_sel      [$];
   mem_data_t row_exp_data [$];
   logic      row_exp_err  [$];

   // Expected DRAM contents
   mem_data_t ref_mem [`MEM_WORDS];
   logic      wr_err_exp;

   int cycle_count   = 0;
   int timeout_limit = 0;

   mem_subsys_top dut_i (
      .clk      (clk),
      .rst_n_i  (rst_n),
      .wb_cyc_i (wb_cyc),
      .wb_stb_i (wb_stb),
      .wb_we_i  (wb_we),
      .wb_adr_i (wb_adr),
      .wb_dat_i (wb_dat_wr),
      .wb_sel_i (wb_sel),
      .wb_ack_o (wb_ack),
      .wb_err_o (wb_err),
      .wb_dat_o (wb_dat_rd),
      .wr_err_o (wr_err)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD/2) clk = ~clk;
   end

   task automatic end_with_failure();
      $display("Result: FAILED");
      $fatal(1, "Simulation stopped at the first error");
   endtask

   task automatic check_data(input string name, input mem_data_t exp, input mem_data_t act);
      if (act !== exp) begin
         $display("Fail %s: expected %h, actual %h", name, exp, act);
         end_with_failure();
      end
   endtask

   task automatic check_ack(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("Fail %s: expected wb_ack %b, actual %b", name, exp, act);
         end_with_failure();
      end
   endtask

   task automatic check_err(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("Fail %s: expected wb_err %b, actual %b", name, exp, act);
         end_with_failure();
      end
   endtask

   task automatic check_wr_err(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("Fail %s: expected wr_err %b, actual %b", name, exp, act);
         end_with_failure();
      end
   endtask

   function automatic logic addr_in_range(input mem_addr_t addr);
      return (addr[`MEM_ADDR_WIDTH-1:BYTE_OFFS] < `MEM_WORDS);
   endfunction

   // Byte strobe merge into the expected contents
   task automatic update_ref(input mem_addr_t addr, input mem_data_t data, input mem_strb_t sel);
      logic [IDX_WIDTH-1:0] idx;
      idx = addr[IDX_WIDTH+BYTE_OFFS-1:BYTE_OFFS];
      if (addr_in_range(addr)) begin
         for (int b = 0; b < STRB_WIDTH; b++) begin
            if (sel[b]) begin
               ref_mem[idx][8*b +: 8] = data[8*b +: 8];
            end
         end
      end
   endtask

   task automatic add_row(input string name, input logic we, input mem_addr_t addr,
                          input mem_data_t data, input mem_strb_t sel,
                          input mem_data_t exp_data, input logic exp_err);
      row_name.push_back(name);
      row_we.push_back(we);
      row_addr.push_back(addr);
      row_data.push_back(data);
      row_sel.push_back(sel);
      row_exp_data.push_back(exp_data);
      row_exp_err.push_back(exp_err);
   endtask

   task automatic load_table();
      // Fresh memory reads as zero
      add_row("rd_unwritten", 1'b0, 28'h0000100, 32'h0, 4'hF, 32'h00000000, 1'b0);
      add_row("wr_full",      1'b1, 28'h0000010, 32'hDEADBEEF, 4'hF, 32'h0, 1'b0);
      add_row("rd_full",      1'b0, 28'h0000010, 32'h0, 4'hF, 32'hDEADBEEF, 1'b0);
      // Byte merge within one word
      add_row("wr_part_init", 1'b1, 28'h0000020, 32'h11223344, 4'hF, 32'h0, 1'b0);
      add_row("wr_part_b0",   1'b1, 28'h0000020, 32'h000000AA, 4'h1, 32'h0, 1'b0);
      add_row("wr_part_b2",   1'b1, 28'h0000020, 32'h00CC0000, 4'h4, 32'h0, 1'b0);
      add_row("wr_part_b3",   1'b1, 28'h0000020, 32'hEE556677, 4'h8, 32'h0, 1'b0);
      add_row("rd_part",      1'b0, 28'h0000020, 32'h0, 4'hF, 32'hEECC33AA, 1'b0);
      // Burst deeper than the FIFO, last one overwrites the first address
      add_row("burst_wr0",    1'b1, 28'h0000040, 32'hC0DE0001, 4'hF, 32'h0, 1'b0);
      add_row("burst_wr1",    1'b1, 28'h0000044, 32'hC0DE0002, 4'hF, 32'h0, 1'b0);
      add_row("burst_wr2",    1'b1, 28'h0000048, 32'hC0DE0003, 4'hF, 32'h0, 1'b0);
      add_row("burst_wr3",    1'b1, 28'h000004C, 32'hC0DE0004, 4'hF, 32'h0, 1'b0);
      add_row("burst_wr4",    1'b1, 28'h0000050, 32'hC0DE0005, 4'hF, 32'h0, 1'b0);
      add_row("burst_wr5",    1'b1, 28'h0000040, 32'hC0DE0006, 4'hF, 32'h0, 1'b0);
      add_row("burst_rd0",    1'b0, 28'h0000040, 32'h0, 4'hF, 32'hC0DE0006, 1'b0);
      add_row("burst_rd1",    1'b0, 28'h0000044, 32'h0, 4'hF, 32'hC0DE0002, 1'b0);
      add_row("burst_rd2",    1'b0, 28'h0000048, 32'h0, 4'hF, 32'hC0DE0003, 1'b0);
      add_row("burst_rd3",    1'b0, 28'h000004C, 32'h0, 4'hF, 32'hC0DE0004, 1'b0);
      add_row("burst_rd4",    1'b0, 28'h0000050, 32'h0, 4'hF, 32'hC0DE0005, 1'b0);
      // Last implemented word
      add_row("wr_top",       1'b1, 28'h0000FFC, 32'h5A5A5A5A, 4'hF, 32'h0, 1'b0);
      add_row("rd_top",       1'b0, 28'h0000FFC, 32'h0, 4'hF, 32'h5A5A5A5A, 1'b0);
      // Decode errors
      add_row("rd_oob",       1'b0, 28'h0001000, 32'h0, 4'hF, 32'h0, 1'b1);
      add_row("rd_oob_high",  1'b0, 28'h0FFFFF0, 32'h0, 4'hF, 32'h0, 1'b1);
      add_row("wr_oob",       1'b1, 28'h0002000, 32'h12345678, 4'hF, 32'h0, 1'b0);
      add_row("rd_after_oob", 1'b0, 28'h0000010, 32'h0, 4'hF, 32'hDEADBEEF, 1'b0);
      add_row("rd_no_alias",  1'b0, 28'h0000000, 32'h0, 4'hF, 32'h00000000, 1'b0);
      add_row("wr_after_err", 1'b1, 28'h0000024, 32'h0BADF00D, 4'hF, 32'h0, 1'b0);
      add_row("rd_after_err", 1'b0, 28'h0000024, 32'h0, 4'hF, 32'h0BADF00D, 1'b0);
   endtask

   task automatic bus_idle();
      wb_cyc    = 1'b0;
      wb_stb    = 1'b0;
      wb_we     = 1'b0;
      wb_adr    = '0;
      wb_dat_wr = '0;
      wb_sel    = '0;
   endtask

   // One Wishbone classic cycle, then at least one idle cycle
   task automatic run_row(input int i);
      logic                 got_ack;
      logic                 got_err;
      mem_data_t            got_data;
      logic [IDX_WIDTH-1:0] idx;
      wb_cyc    = 1'b1;
      wb_stb    = 1'b1;
      wb_we     = row_we[i];
      wb_adr    = row_addr[i];
      wb_dat_wr = row_data[i];
      wb_sel    = row_sel[i];
      do begin
         @(posedge clk);
         #DRIVE_DELAY;
      end while (!wb_ack && !wb_err);
      got_ack  = wb_ack;
      got_err  = wb_err;
      got_data = wb_dat_rd;
      bus_idle();
      check_ack(row_name[i], !row_exp_err[i], got_ack);
      check_err(row_name[i], row_exp_err[i], got_err);
      if (row_we[i]) begin
         update_ref(row_addr[i], row_data[i], row_sel[i]);
         if (!addr_in_range(row_addr[i])) begin
            wr_err_exp = 1'b1;
         end else if (!wr_err_exp) begin
            check_wr_err(row_name[i], 1'b0, wr_err);
         end
      end else begin
         if (!row_exp_err[i]) begin
            idx = row_addr[i][IDX_WIDTH+BYTE_OFFS-1:BYTE_OFFS];
            check_data(row_name[i], ref_mem[idx], got_data);
         end
         // Decode errors come back with zero data
         check_data(row_name[i], row_exp_data[i], got_data);
         // Reads finish after every earlier write response
         check_wr_err(row_name[i], wr_err_exp, wr_err);
      end
      @(posedge clk);
      #DRIVE_DELAY;
   endtask

   always @(posedge clk) begin
      cycle_count = cycle_count + 1;
      if (timeout_limit > 0 && cycle_count > timeout_limit) begin
         $display("Timeout after %0d cycles, an access never completed", cycle_count);
         end_with_failure();
      end
   end

   initial begin
      int gap;
      void'($urandom(89));
      rst_n      = 1'b0;
      wr_err_exp = 1'b0;
      bus_idle();
      for (int w = 0; w < `MEM_WORDS; w++) begin
         ref_mem[w] = '0;
      end
      load_table();
      timeout_limit = 60 * row_name.size() + 100;

      repeat (2) @(posedge clk);
      #DRIVE_DELAY;
      check_ack("reset", 1'b0, wb_ack);
      check_err("reset", 1'b0, wb_err);
      check_wr_err("reset", 1'b0, wr_err);
      rst_n = 1'b1;

      for (int i = 0; i < row_name.size(); i++) begin
         gap = int'($urandom % 4);
         repeat (gap) begin
            @(posedge clk);
            #DRIVE_DELAY;
         end
         run_row(i);
      end

      $display("%0d Wishbone accesses checked", row_name.size());
      $display("Result: PASSED");
      $finish;
   end

endmodule
